// ==== aes_types_pkg.sv ====
`default_nettype none

package aes_types_pkg;

  // Byte 0 sits in bits [127:120], column order as in FIPS-197
  typedef logic [127:0] block_t;
  typedef logic [31:0]  word_t;
  typedef logic [7:0]   aes_byte_t;
  typedef logic [3:0]   round_t;

  localparam round_t    NUM_ROUNDS = 4'd10;
  localparam aes_byte_t GF_POLY    = 8'h1b;
  localparam aes_byte_t AFFINE_C   = 8'h63;
  localparam aes_byte_t RCON_INIT  = 8'h01;

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic aes_byte_t gf_xtime(input aes_byte_t a);
    return {a[6:0], 1'b0} ^ (a[7] ? GF_POLY : 8'h00);
  endfunction

endpackage

`default_nettype wire

// ==== aes_ctrl_pkg.sv ====
`default_nettype none

package aes_ctrl_pkg;

  typedef enum logic {
    IDLE,
    RUN
  } ctrl_state_e;

  // Per-cycle commands from the controller to the datapath
  typedef struct packed {
    logic load;
    logic advance;
    logic final_round;
  } round_ctrl_t;

endpackage

`default_nettype wire

// ==== aes_sbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_sbox (
  input  wire aes_types_pkg::aes_byte_t in_byte,
  output aes_types_pkg::aes_byte_t      out_byte
);
  import aes_types_pkg::*;

  function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
    aes_byte_t acc;
    aes_byte_t sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = gf_xtime(sh);
    end
    return acc;
  endfunction

  aes_byte_t x2, x3, x6, x12, x15;
  aes_byte_t x30, x60, x120, x240, x252;
  aes_byte_t inv;

  // Inverse as x^254, zero falls out as zero
  assign x2   = gf_mul(in_byte, in_byte);
  assign x3   = gf_mul(x2, in_byte);
  assign x6   = gf_mul(x3, x3);
  assign x12  = gf_mul(x6, x6);
  assign x15  = gf_mul(x12, x3);
  assign x30  = gf_mul(x15, x15);
  assign x60  = gf_mul(x30, x30);
  assign x120 = gf_mul(x60, x60);
  assign x240 = gf_mul(x120, x120);
  assign x252 = gf_mul(x240, x12);
  assign inv  = gf_mul(x252, x2);

  // Affine map
  assign out_byte = inv
                  ^ {inv[6:0], inv[7]}
                  ^ {inv[5:0], inv[7:6]}
                  ^ {inv[4:0], inv[7:5]}
                  ^ {inv[3:0], inv[7:4]}
                  ^ AFFINE_C;

endmodule

`default_nettype wire

// ==== aes_key_schedule.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire aes_ctrl_pkg::round_ctrl_t   ctrl,
  input  wire aes_types_pkg::block_t       key,
  input  wire aes_types_pkg::round_t       round,
  output aes_types_pkg::block_t            round_key
);
  import aes_types_pkg::*;

  function automatic aes_byte_t round_rcon(input round_t r);
    aes_byte_t rc;
    rc = RCON_INIT;
    for (int i = 1; i < NUM_ROUNDS; i++) begin
      if (round_t'(i) < r) begin
        rc = gf_xtime(rc);
      end
    end
    return rc;
  endfunction

  block_t    key_q;
  word_t     w0, w1, w2, w3;
  word_t     rot_word, sub_word, temp;
  word_t     n0, n1, n2, n3;
  aes_byte_t rcon;

  // Previous round key
  assign {w0, w1, w2, w3} = key_q;

  assign rot_word = {w3[23:0], w3[31:24]};
  assign rcon     = round_rcon(round);

  for (genvar i = 0; i < 4; i++) begin : g_sub
    aes_sbox i_sbox (
      .in_byte  (rot_word[31-8*i -: 8]),
      .out_byte (sub_word[31-8*i -: 8])
    );
  end

  assign temp = sub_word ^ {rcon, 24'h000000};
  assign n0   = w0 ^ temp;
  assign n1   = w1 ^ n0;
  assign n2   = w2 ^ n1;
  assign n3   = w3 ^ n2;

  assign round_key = {n0, n1, n2, n3};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_q <= '0;
    end else if (ctrl.load) begin
      key_q <= key;
    end else if (ctrl.advance) begin
      key_q <= round_key;
    end
  end

endmodule

`default_nettype wire

// ==== aes_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_round (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire aes_ctrl_pkg::round_ctrl_t   ctrl,
  input  wire aes_types_pkg::block_t       plaintext,
  input  wire aes_types_pkg::block_t       key,
  input  wire aes_types_pkg::block_t       round_key,
  output aes_types_pkg::block_t            state_next
);
  import aes_types_pkg::*;

  function automatic word_t mix_column(input word_t col);
    aes_byte_t a0;
    aes_byte_t a1;
    aes_byte_t a2;
    aes_byte_t a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {gf_xtime(a0) ^ gf_xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ gf_xtime(a1) ^ gf_xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ gf_xtime(a2) ^ gf_xtime(a3) ^ a3,
            gf_xtime(a0) ^ a0 ^ a1 ^ a2 ^ gf_xtime(a3)};
  endfunction

  block_t state_q;
  block_t sb;
  block_t sr;
  block_t mc;

  // SubBytes
  for (genvar i = 0; i < 16; i++) begin : g_sub
    aes_sbox i_sbox (
      .in_byte  (state_q[127-8*i -: 8]),
      .out_byte (sb[127-8*i -: 8])
    );
  end

  // ShiftRows, row r rotates left by r columns
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        sr[127-8*(4*c+r) -: 8] = sb[127-8*(4*((c+r)%4)+r) -: 8];
      end
    end
  end

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mc[127-32*c -: 32] = mix_column(sr[127-32*c -: 32]);
    end
  end

  // Final round skips MixColumns
  assign state_next = (ctrl.final_round ? sr : mc) ^ round_key;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '0;
    end else if (ctrl.load) begin
      state_q <= plaintext ^ key;
    end else if (ctrl.advance) begin
      state_q <= state_next;
    end
  end

endmodule

`default_nettype wire

// ==== aes_round_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_round_counter (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire aes_ctrl_pkg::round_ctrl_t   ctrl,
  output aes_types_pkg::round_t            round,
  output logic                             last
);
  import aes_types_pkg::*;

  assign last = (round == NUM_ROUNDS);

  // Wraps to 0 once the last round is done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      round <= '0;
    end else if (ctrl.load) begin
      round <= round_t'(1);
    end else if (ctrl.advance) begin
      round <= last ? '0 : round + round_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== aes_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_ctrl_fsm (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      start,
  input  wire                      last,
  output aes_ctrl_pkg::round_ctrl_t ctrl,
  output logic                     busy,
  output logic                     done
);
  import aes_ctrl_pkg::*;

  ctrl_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (start) state_d = RUN;
      RUN:  if (last) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    ctrl.load        = (state_q == IDLE) && start;
    ctrl.advance     = (state_q == RUN);
    ctrl.final_round = (state_q == RUN) && last;
  end

  assign busy = (state_q == RUN);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      done    <= 1'b0;
    end else begin
      state_q <= state_d;
      done    <= ctrl.advance && ctrl.final_round;
    end
  end

endmodule

`default_nettype wire

// ==== aes_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_core (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        start,
  input  wire aes_types_pkg::block_t plaintext,
  input  wire aes_types_pkg::block_t key,
  output aes_types_pkg::block_t      ciphertext,
  output logic                       done,
  output logic                       busy
);
  import aes_types_pkg::*;
  import aes_ctrl_pkg::*;

  round_ctrl_t ctrl;
  round_t      round;
  logic        last;
  block_t      round_key;
  block_t      state_next;

  aes_ctrl_fsm i_ctrl_fsm (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .last  (last),
    .ctrl  (ctrl),
    .busy  (busy),
    .done  (done)
  );

  aes_round_counter i_round_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .round (round),
    .last  (last)
  );

  aes_key_schedule i_key_schedule (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .key       (key),
    .round     (round),
    .round_key (round_key)
  );

  aes_round i_round (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .plaintext  (plaintext),
    .key        (key),
    .round_key  (round_key),
    .state_next (state_next)
  );

  // Holds until the next block completes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ciphertext <= '0;
    end else if (ctrl.advance && ctrl.final_round) begin
      ciphertext <= state_next;
    end
  end

endmodule

`default_nettype wire

// ==== tb_aes_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aes_core;
  import aes_types_pkg::*;

  localparam int     CLK_PERIOD     = 100;
  localparam int     LATENCY        = 10;
  localparam int     NUM_RANDOM     = 200;
  localparam int     NUM_VECTORS    = NUM_RANDOM + 3;
  localparam int     TIMEOUT_CYCLES = NUM_VECTORS * 12 + 200;
  localparam block_t FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam block_t FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam block_t FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic   clk;
  logic   rst_n;
  logic   start;
  block_t plaintext;
  block_t key;
  block_t ciphertext;
  logic   done;
  logic   busy;

  aes_byte_t sbox_tab [256];
  block_t    exp_q [$];
  int        accept_q [$];
  int        done_cycles [$];
  int        cycle = 0;
  int        value_errors = 0;
  int        other_errors = 0;

  aes_core i_aes_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .plaintext  (plaintext),
    .key        (key),
    .ciphertext (ciphertext),
    .done       (done),
    .busy       (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic aes_byte_t xtime_ref(input aes_byte_t a);
    return a[7] ? ({a[6:0], 1'b0} ^ 8'h1b) : {a[6:0], 1'b0};
  endfunction

  function automatic aes_byte_t rotl8(input aes_byte_t b, input int n);
    return (b << n) | (b >> (8 - n));
  endfunction

  // Powers of the generator 3 give the inverse as g^(255-i)
  function automatic void build_sbox();
    aes_byte_t pow_tab [255];
    aes_byte_t a;
    aes_byte_t inv;
    a = 8'h01;
    for (int i = 0; i < 255; i++) begin
      pow_tab[i] = a;
      a = a ^ xtime_ref(a);
    end
    sbox_tab[0] = 8'h63;
    for (int i = 0; i < 255; i++) begin
      inv = pow_tab[(255 - i) % 255];
      sbox_tab[pow_tab[i]] = inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3)
                           ^ rotl8(inv, 4) ^ 8'h63;
    end
  endfunction

  function automatic aes_byte_t sub_byte(input aes_byte_t b);
    return sbox_tab[b];
  endfunction

  function automatic block_t aes_ref(input block_t pt, input block_t k);
    word_t     w [44];
    aes_byte_t s [16];
    aes_byte_t t [16];
    word_t     tmp;
    aes_byte_t rc;
    block_t    res;
    for (int i = 0; i < 4; i++) begin
      w[i] = k[127-32*i -: 32];
    end
    rc = 8'h01;
    for (int i = 4; i < 44; i++) begin
      tmp = w[i-1];
      if (i % 4 == 0) begin
        tmp = {sub_byte(tmp[23:16]) ^ rc, sub_byte(tmp[15:8]),
               sub_byte(tmp[7:0]), sub_byte(tmp[31:24])};
        rc = xtime_ref(rc);
      end
      w[i] = w[i-4] ^ tmp;
    end
    for (int i = 0; i < 16; i++) begin
      s[i] = pt[127-8*i -: 8] ^ k[127-8*i -: 8];
    end
    for (int rnd = 1; rnd <= 10; rnd++) begin
      // SubBytes with ShiftRows folded into the index
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          t[4*c+r] = sub_byte(s[4*((c+r)%4)+r]);
        end
      end
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          if (rnd < 10) begin
            // 2*a(r) + 3*a(r+1) + a(r+2) + a(r+3)
            s[4*c+r] = xtime_ref(t[4*c+r]) ^ xtime_ref(t[4*c+(r+1)%4])
                     ^ t[4*c+(r+1)%4] ^ t[4*c+(r+2)%4] ^ t[4*c+(r+3)%4];
          end else begin
            s[4*c+r] = t[4*c+r];
          end
          s[4*c+r] = s[4*c+r] ^ w[4*rnd+c][31-8*r -: 8];
        end
      end
    end
    for (int i = 0; i < 16; i++) begin
      res[127-8*i -: 8] = s[i];
    end
    return res;
  endfunction

  task automatic check_block(input string name, input block_t got, input block_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED %s: got %h, expected %h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      value_errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    other_errors++;
    $display("%s", msg);
  endtask

  // Holds start until the block is taken or max_cycles run out
  task automatic apply_start(input block_t pt, input block_t k, input int max_cycles,
                             output bit accepted);
    accepted = 1'b0;
    for (int i = 0; i < max_cycles && !accepted; i++) begin
      #1;
      start     = 1'b1;
      plaintext = pt;
      key       = k;
      if (!busy) begin
        exp_q.push_back(aes_ref(pt, k));
        accept_q.push_back(cycle + 1);
        accepted = 1'b1;
      end
      @(posedge clk);
    end
    #1;
    start = 1'b0;
    @(posedge clk);
  endtask

  task automatic wait_results();
    while (exp_q.size() > 0) begin
      @(posedge clk);
    end
  endtask

  initial begin : compare_proc
    logic   busy_exp;
    logic   done_exp;
    block_t last_ct;
    last_ct = '0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        busy_exp = 1'b0;
        done_exp = 1'b0;
        if (accept_q.size() > 0 && cycle >= accept_q[0]) begin
          busy_exp = (cycle - accept_q[0]) < LATENCY;
          done_exp = (cycle - accept_q[0]) == LATENCY;
        end
        check_bit("busy", busy, busy_exp);
        check_bit("done", done, done_exp);
        if (done && exp_q.size() > 0) begin
          check_cycles("latency", cycle - accept_q[0], LATENCY);
          check_block("ciphertext", ciphertext, exp_q[0]);
          void'(exp_q.pop_front());
          void'(accept_q.pop_front());
          done_cycles.push_back(cycle);
          last_ct = ciphertext;
        end else if (!done) begin
          check_block("ciphertext held", ciphertext, last_ct);
          if (accept_q.size() > 0 && cycle - accept_q[0] > LATENCY) begin
            note_failure($sformatf("No done for the block accepted at cycle %0d",
                                   accept_q[0]));
            void'(exp_q.pop_front());
            void'(accept_q.pop_front());
          end
        end
      end
    end
  end

  initial begin : watchdog_proc
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the DUT stopped producing results", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main_proc
    int unsigned seed;
    block_t      pt;
    block_t      k;
    bit          accepted;
    int          base;
    clk       = 1'b0;
    rst_n     = 1'b0;
    start     = 1'b0;
    plaintext = '0;
    key       = '0;
    seed      = 32;
    void'($urandom(seed));
    build_sbox();

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("done after reset", done, 1'b0);
    check_bit("busy after reset", busy, 1'b0);
    check_block("ciphertext after reset", ciphertext, '0);
    @(posedge clk);

    // FIPS-197 Appendix C.1
    check_block("aes_ref C.1", aes_ref(FIPS_PT, FIPS_KEY), FIPS_CT);
    apply_start(FIPS_PT, FIPS_KEY, 1, accepted);
    if (!accepted) note_failure("Start for the C.1 vector was not taken while idle");
    wait_results();
    check_block("ciphertext C.1", ciphertext, FIPS_CT);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      pt = {$urandom, $urandom, $urandom, $urandom};
      k  = {$urandom, $urandom, $urandom, $urandom};
      apply_start(pt, k, 1, accepted);
      if (!accepted) note_failure("Start for a random vector was not taken while idle");
      wait_results();
    end

    // Busy start ignored and a start held into the done cycle taken back to back
    base = done_cycles.size();
    pt   = {$urandom, $urandom, $urandom, $urandom};
    k    = {$urandom, $urandom, $urandom, $urandom};
    apply_start(pt, k, 1, accepted);
    if (!accepted) note_failure("First block of the overlap test was not taken");
    apply_start(~pt, ~k, 3, accepted);
    if (accepted) note_failure("Busy was low while the first block was running");
    apply_start(pt ^ 128'h5a, k, 20, accepted);
    if (!accepted) note_failure("Start held through the done cycle was never taken");
    wait_results();
    if (done_cycles.size() >= base + 2) begin
      check_cycles("done spacing", done_cycles[base+1] - done_cycles[base], LATENCY + 1);
    end else begin
      note_failure("Overlap test did not produce two results");
    end

    repeat (2) @(posedge clk);
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
aes_types_pkg.sv
aes_ctrl_pkg.sv
aes_sbox.sv
aes_key_schedule.sv
aes_round.sv
aes_round_counter.sv
aes_ctrl_fsm.sv
aes_core.sv
tb_aes_core.sv

// ==== Bender.yml ====
package:
  name: aes_core

sources:
  - aes_types_pkg.sv
  - aes_ctrl_pkg.sv
  - aes_sbox.sv
  - aes_key_schedule.sv
  - aes_round.sv
  - aes_round_counter.sv
  - aes_ctrl_fsm.sv
  - aes_core.sv
  - target: simulation
    files:
      - tb_aes_core.sv
